//--- cache_consts.svh
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// address split  [tag 6] [set 6] [byte offset 4]
`define TAG_W 6
`define SET_W 6
`define OFS_W 4
`define ADDR_W 16 // tag + set + offset

`define WORD_W 16 // cpu and memory word
`define WORDS_PER_BLOCK 8 // 16 byte blocks
`define NUM_SETS 64 // two ways each

// main memory holds 32K words, so a word address drops addr[0]
`define MEM_AW 15

// cycles from a read strobe to its data strobe
`define MEM_LATENCY 4

`endif

//--- cache_pkg.sv
`include "cache_consts.svh"

package cache_pkg;

	// encoded operation from the controller to the cache
	typedef enum logic [1:0] {
		OP_READ    = 2'd0, // lookup, lru update on hit
		OP_FILL    = 2'd1, // write one word of the block
		OP_SET_TAG = 2'd2, // commit the filled block
		OP_IDLE    = 2'd3
	} cache_op_e;

	// controller states
	typedef enum logic [2:0] {
		ST_IDLE    = 3'd0,
		ST_LOOKUP  = 3'd1,
		ST_FETCH   = 3'd2, // streaming the block in from memory
		ST_COMMIT  = 3'd3,
		ST_RESPOND = 3'd4
	} fsm_state_e;

	// one way's metadata entry, lru_n is low for the way to evict
	typedef struct packed {
		logic              valid;
		logic              lru_n;
		logic [`TAG_W-1:0] tag;
	} meta_t;

	typedef struct packed {
		logic               write; // 1 = store
		logic [`ADDR_W-1:0] addr;  // byte address
		logic [`WORD_W-1:0] wdata;
	} cpu_req_t;

	typedef struct packed {
		logic [`WORD_W-1:0] rdata; // 0 for stores
		logic               hit;
	} cpu_rsp_t;

	typedef struct packed {
		logic               write;
		logic [`MEM_AW-1:0] waddr; // word address
		logic [`WORD_W-1:0] wdata;
	} mem_req_t;

endpackage

//--- cache_toplevel.sv
`include "cache_consts.svh"

// two way set associative cache, tag compare and next state metadata
// data is filled word by word, the tag write last commits the block
module cache_toplevel import cache_pkg::*; (
	input  logic               clk,
	input  logic               rst,
	input  logic [`ADDR_W-1:0] addr,
	input  logic [`WORD_W-1:0] wdata,  // store data or fill word
	input  logic               access, // memory operation in progress
	input  cache_op_e          cacheop,
	output logic [`WORD_W-1:0] rdata,
	output logic               miss
);

	logic [`TAG_W-1:0]           tag_in;
	logic [`SET_W-1:0]           set_idx;
	logic [`OFS_W-2:0]           word_sel; // word within the block
	meta_t                       meta_q [2];
	meta_t                       meta_d [2];
	logic [1:0]                  hit_way;
	logic [1:0]                  lrus_n;
	logic [1:0]                  miss_way; // one-hot victim
	logic [1:0]                  way_sel;  // way the data array works on
	logic [1:0]                  install;  // way getting the new tag
	logic                        hit;
	logic                        data_we;
	logic                        meta_we;
	logic [`NUM_SETS-1:0]        set_oh;
	logic [2*`NUM_SETS-1:0]      block_en;
	logic [`WORDS_PER_BLOCK-1:0] word_en;
	logic [`WORD_W-1:0]          data_out;

	// address fields
	assign tag_in   = addr[`ADDR_W-1 -: `TAG_W];
	assign set_idx  = addr[`OFS_W +: `SET_W];
	assign word_sel = addr[`OFS_W-1:1]; // addr[0] is the byte within the word

	// both ways are read in the same cycle and compared
	assign hit_way[0] = meta_q[0].valid && (meta_q[0].tag == tag_in);
	assign hit_way[1] = meta_q[1].valid && (meta_q[1].tag == tag_in);
	assign hit  = access & (|hit_way);
	assign miss = access & ~(|hit_way);

	// victim: cold set takes way 0, otherwise the way with lru_n low
	assign lrus_n   = {meta_q[1].lru_n, meta_q[0].lru_n};
	assign miss_way = (lrus_n == 2'b00) ? 2'b01 : ~lrus_n;

	always_comb begin
		case (cacheop)
			OP_READ: way_sel = hit_way; // none on a miss
			OP_FILL: way_sel = miss ? miss_way : hit_way; // store hit uses the hit way
			default: way_sel = 2'b00;
		endcase
	end

	// set and word decode
	assign set_oh  = `NUM_SETS'(1) << set_idx;
	assign word_en = `WORDS_PER_BLOCK'(1) << word_sel;
	assign block_en = way_sel[0] ? {{`NUM_SETS{1'b0}}, set_oh} :
	                  way_sel[1] ? {set_oh, {`NUM_SETS{1'b0}}} :
	                  '0;

	assign data_we = access && (cacheop == OP_FILL);
	// metadata is rewritten on every read hit for the lru, and on tag commit
	assign meta_we = access && ((cacheop == OP_SET_TAG) || (cacheop == OP_READ && hit));

	assign install = (cacheop == OP_SET_TAG && miss) ? miss_way : 2'b00;

	// next state metadata, both ways of the set written together
	always_comb begin
		for (int w = 0; w < 2; w++) begin
			meta_d[w].valid = meta_q[w].valid | install[w]; // stays valid until reset
			meta_d[w].tag   = install[w] ? tag_in : meta_q[w].tag;
			case (cacheop)
				OP_READ:    meta_d[w].lru_n = miss ? meta_q[w].lru_n : hit_way[w];
				OP_SET_TAG: meta_d[w].lru_n = miss ? miss_way[w] : meta_q[w].lru_n;
				default:    meta_d[w].lru_n = meta_q[w].lru_n; // fill leaves lru alone
			endcase
		end
	end

	// zero with no access or no enabled block
	assign rdata = (access && (block_en != '0)) ? data_out : '0;

	data_array u_data (
		.clk      (clk),
		.rst      (rst),
		.din      (wdata),
		.we       (data_we),
		.block_en (block_en),
		.word_en  (word_en),
		.dout     (data_out)
	);

	meta_array way0 (
		.clk  (clk),
		.rst  (rst),
		.din  (meta_d[0]),
		.we   (meta_we),
		.set  (set_idx),
		.dout (meta_q[0])
	);

	meta_array way1 (
		.clk  (clk),
		.rst  (rst),
		.din  (meta_d[1]),
		.we   (meta_we),
		.set  (set_idx),
		.dout (meta_q[1])
	);

	// a tag is only installed on a miss, so it never sits in both ways
	a_single_hit: assert property (@(posedge clk) disable iff (rst)
		!(hit_way[0] && hit_way[1]))
		else $error("cache_toplevel: tag hit in both ways of set %0d", set_idx);

endmodule

//--- data_array.sv
`include "cache_consts.svh"

// data store for both ways, way 1 blocks sit NUM_SETS above way 0
module data_array (
	input  logic                          clk,
	input  logic                          rst,
	input  logic [`WORD_W-1:0]            din,
	input  logic                          we,
	input  logic [2*`NUM_SETS-1:0]        block_en, // one-hot or none
	input  logic [`WORDS_PER_BLOCK-1:0]   word_en,  // one-hot
	output logic [`WORD_W-1:0]            dout
);

	logic [`WORD_W-1:0] mem [2*`NUM_SETS][`WORDS_PER_BLOCK];

	// enabled word of the enabled block is written on the edge
	always_ff @(posedge clk) begin
		if (we) begin
			for (int b = 0; b < 2*`NUM_SETS; b++) begin
				for (int w = 0; w < `WORDS_PER_BLOCK; w++) begin
					if (block_en[b] && word_en[w])
						mem[b][w] <= din;
				end
			end
		end
	end

	// async read, an or of the single selected word
	always_comb begin
		dout = '0; // no block enabled reads zero
		for (int b = 0; b < 2*`NUM_SETS; b++) begin
			for (int w = 0; w < `WORDS_PER_BLOCK; w++) begin
				if (block_en[b] && word_en[w])
					dout = dout | mem[b][w];
			end
		end
	end

	// two enabled blocks would or two ways together
	a_block_onehot: assert property (@(posedge clk) disable iff (rst)
		$onehot0(block_en))
		else $error("data_array: more than one block enabled");

endmodule

//--- fill_fsm.sv
`include "cache_consts.svh"

// controller that sequences lookup, block fill from memory, tag commit and write-through
module fill_fsm import cache_pkg::*; (
	input  logic               clk,
	input  logic               rst,
	input  logic               req_valid,
	input  cpu_req_t           req,
	output logic               busy,
	output logic               rsp_valid,
	output cpu_rsp_t           rsp,
	output logic [`ADDR_W-1:0] addr,
	output logic [`WORD_W-1:0] wdata,
	output logic               access,
	output cache_op_e          cacheop,
	input  logic [`WORD_W-1:0] rdata,
	input  logic               miss,
	output logic               mem_valid,
	output mem_req_t           mem_req,
	input  logic               mem_rvalid,
	input  logic [`WORD_W-1:0] mem_rdata
);

	fsm_state_e            state_q, state_d;
	cpu_req_t              req_q;     // latched request
	cpu_rsp_t              rsp_q;
	logic                  missed_q;  // load missed so the re-read reports hit = 0
	logic [`OFS_W-1:0]     req_cnt;   // reads issued with the msb set once all 8 are out
	logic [`OFS_W-2:0]     fill_cnt;  // words returned

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_IDLE:    if (req_valid) state_d = ST_LOOKUP;
			ST_LOOKUP:  state_d = (!req_q.write && miss) ? ST_FETCH : ST_RESPOND;
			ST_FETCH:   if (mem_rvalid && fill_cnt == '1) state_d = ST_COMMIT; // last word
			ST_COMMIT:  state_d = ST_LOOKUP; // re-read now hits
			ST_RESPOND: state_d = ST_IDLE;
			default:    state_d = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q  <= ST_IDLE;
			missed_q <= 1'b0;
			req_cnt  <= '0;
			fill_cnt <= '0;
		end else begin
			state_q <= state_d;
			if (state_q == ST_IDLE && req_valid)
				missed_q <= 1'b0;
			if (state_q == ST_LOOKUP && state_d == ST_FETCH) begin
				missed_q <= 1'b1;
				req_cnt  <= '0;
				fill_cnt <= '0;
			end
			if (state_q == ST_FETCH && mem_valid)
				req_cnt <= req_cnt + 1;
			if (state_q == ST_FETCH && mem_rvalid)
				fill_cnt <= fill_cnt + 1; // returns arrive in request order
		end
	end

	always_ff @(posedge clk) begin
		if (state_q == ST_IDLE && req_valid)
			req_q <= req;
		if (state_q == ST_LOOKUP && state_d == ST_RESPOND)
			rsp_q <= req_q.write ? {`WORD_W'(0), !miss} : {rdata, !missed_q};
	end

	assign busy      = (state_q != ST_IDLE);
	assign rsp_valid = (state_q == ST_RESPOND);
	assign rsp       = rsp_q;

	assign access = (state_q == ST_LOOKUP) || (state_q == ST_FETCH) || (state_q == ST_COMMIT);
	// fills walk the words of the block and the other states use the cpu address
	assign addr  = (state_q == ST_FETCH) ? {req_q.addr[`ADDR_W-1:`OFS_W], fill_cnt, 1'b0} :
	               req_q.addr;
	assign wdata = (state_q == ST_FETCH) ? mem_rdata : req_q.wdata;

	always_comb begin
		case (state_q)
			// store miss must not touch the victim way
			ST_LOOKUP: cacheop = req_q.write ? (miss ? OP_IDLE : OP_FILL) : OP_READ;
			ST_FETCH:  cacheop = mem_rvalid ? OP_FILL : OP_IDLE;
			ST_COMMIT: cacheop = OP_SET_TAG;
			default:   cacheop = OP_IDLE;
		endcase
	end

	// write-through in the lookup cycle and one block read per cycle in fetch
	assign mem_valid     = (state_q == ST_LOOKUP && req_q.write) ||
	                       (state_q == ST_FETCH && !req_cnt[`OFS_W-1]);
	assign mem_req.write = (state_q == ST_LOOKUP);
	assign mem_req.waddr = (state_q == ST_LOOKUP) ? req_q.addr[`ADDR_W-1:1] :
	                       {req_q.addr[`ADDR_W-1:`OFS_W], req_cnt[`OFS_W-2:0]};
	assign mem_req.wdata = req_q.wdata;

	a_no_req_busy: assert property (@(posedge clk) disable iff (rst)
		busy |-> !req_valid)
		else $error("fill_fsm: cpu request while busy");

	// memory only answers reads that this controller issued in fetch
	a_rvalid_fetch: assert property (@(posedge clk) disable iff (rst)
		mem_rvalid |-> state_q == ST_FETCH)
		else $error("fill_fsm: memory data outside a block fetch");

endmodule

//--- main_memory.sv
`include "cache_consts.svh"

// word memory, reads return after a fixed latency, writes land at the edge
module main_memory import cache_pkg::*; (
	input  logic               clk,
	input  logic               rst,
	input  logic               mem_valid,
	input  mem_req_t           mem_req,
	output logic               mem_rvalid,
	output logic [`WORD_W-1:0] mem_rdata
);

	logic [`WORD_W-1:0]      mem [2**`MEM_AW];
	logic [`MEM_LATENCY-1:0] vld_pipe;                  // read valids in flight
	logic [`WORD_W-1:0]      data_pipe [`MEM_LATENCY];

	// fixed pattern, each word is its index xor a5c3
	initial begin
		for (int i = 0; i < 2**`MEM_AW; i++)
			mem[i] = `WORD_W'(i) ^ 16'hA5C3;
	end

	always_ff @(posedge clk) begin
		if (mem_valid && mem_req.write)
			mem[mem_req.waddr] <= mem_req.wdata;
	end

	always_ff @(posedge clk) begin
		if (rst)
			vld_pipe <= '0;
		else
			vld_pipe <= {vld_pipe[`MEM_LATENCY-2:0], mem_valid && !mem_req.write};
	end

	// data read at request time and carried down the pipe
	always_ff @(posedge clk) begin
		data_pipe[0] <= mem[mem_req.waddr];
		for (int s = 1; s < `MEM_LATENCY; s++)
			data_pipe[s] <= data_pipe[s-1];
	end

	assign mem_rvalid = vld_pipe[`MEM_LATENCY-1];
	assign mem_rdata  = data_pipe[`MEM_LATENCY-1];

endmodule

//--- mem_system.sv
`include "cache_consts.svh"

// cpu facing top: controller, cache and backing memory
module mem_system import cache_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     req_valid,
	input  cpu_req_t req,
	output logic     busy,
	output logic     rsp_valid,
	output cpu_rsp_t rsp
);

	logic [`ADDR_W-1:0] c_addr;
	logic [`WORD_W-1:0] c_wdata;
	logic [`WORD_W-1:0] c_rdata;
	logic               c_access;
	logic               c_miss;
	cache_op_e          c_op;
	logic               mem_valid;
	mem_req_t           mem_req;
	logic               mem_rvalid;
	logic [`WORD_W-1:0] mem_rdata;

	fill_fsm u_fsm (
		.clk        (clk),
		.rst        (rst),
		.req_valid  (req_valid),
		.req        (req),
		.busy       (busy),
		.rsp_valid  (rsp_valid),
		.rsp        (rsp),
		.addr       (c_addr),
		.wdata      (c_wdata),
		.access     (c_access),
		.cacheop    (c_op),
		.rdata      (c_rdata),
		.miss       (c_miss),
		.mem_valid  (mem_valid),
		.mem_req    (mem_req),
		.mem_rvalid (mem_rvalid),
		.mem_rdata  (mem_rdata)
	);

	cache_toplevel u_cache (
		.clk     (clk),
		.rst     (rst),
		.addr    (c_addr),
		.wdata   (c_wdata),
		.access  (c_access),
		.cacheop (c_op),
		.rdata   (c_rdata),
		.miss    (c_miss)
	);

	main_memory u_mem (
		.clk        (clk),
		.rst        (rst),
		.mem_valid  (mem_valid),
		.mem_req    (mem_req),
		.mem_rvalid (mem_rvalid),
		.mem_rdata  (mem_rdata)
	);

endmodule

//--- meta_array.sv
`include "cache_consts.svh"

// one way's metadata, cleared to invalid and cold by reset
module meta_array import cache_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  meta_t             din,
	input  logic              we,
	input  logic [`SET_W-1:0] set,
	output meta_t             dout
);

	meta_t entries [`NUM_SETS];

	always_ff @(posedge clk) begin
		if (rst) begin
			// all zero = invalid, lru_n 0 on both ways makes the set cold
			for (int s = 0; s < `NUM_SETS; s++)
				entries[s] <= '0;
		end else if (we) begin
			entries[set] <= din;
		end
	end

	assign dout = entries[set]; // async read of the addressed set

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the memory system testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
	--top-module tb_mem_system -f tb.f --Mdir obj_dir -o Vtb_mem_system
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/Vtb_mem_system > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TEST FAILED" sim.log; then
	exit 1
fi
exit 0

//--- tb.f
+incdir+.
cache_pkg.sv
data_array.sv
meta_array.sv
cache_toplevel.sv
fill_fsm.sv
main_memory.sv
mem_system.sv
tb_mem_system.sv

//--- tb_mem_system.sv
`include "cache_consts.svh"

module tb_mem_system import cache_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ns;

	localparam int CLK_PERIOD = 100;
	localparam int MISS_BOUND = 2*`WORDS_PER_BLOCK + `MEM_LATENCY; // loose bound on a load miss
	localparam int N_DIR      = 20;  // directed requests
	localparam int N_RAND     = 300;
	localparam int WATCHDOG_CYCLES = 20 + (N_DIR + N_RAND) * (MISS_BOUND + 2) + 100;

	// what the compare process expects for one request
	typedef struct packed {
		cpu_rsp_t           rsp;
		logic               fast;   // store or load hit, answered in 2 cycles
		logic               write;
		logic [`ADDR_W-1:0] addr;
		logic [31:0]        issued; // cycle count at the request strobe
	} exp_t;

	logic        clk = 1'b0;
	logic        rst;
	logic        req_valid;
	cpu_req_t    req;
	logic        busy;
	logic        rsp_valid;
	cpu_rsp_t    rsp;
	logic [31:0] cycle = '0;
	logic [15:0] lfsr_q;
	int          mismatch_cnt = 0;
	int          other_cnt = 0;
	int          req_cnt = 0;
	int          rsp_cnt = 0;
	exp_t        exp_q [$];

	// reference model state
	logic [`WORD_W-1:0] ref_mem [2**`MEM_AW];
	logic               ref_valid [`NUM_SETS][2];
	logic [`TAG_W-1:0]  ref_tag [`NUM_SETS][2];
	logic               ref_lru_n [`NUM_SETS][2]; // low marks the way to evict

	mem_system dut (
		.clk       (clk),
		.rst       (rst),
		.req_valid (req_valid),
		.req       (req),
		.busy      (busy),
		.rsp_valid (rsp_valid),
		.rsp       (rsp)
	);

	always #(CLK_PERIOD/2) clk = ~clk;
	always @(posedge clk) cycle <= cycle + 1;

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		logic [15:0] n;
		n = s >> 1;
		if (s[0])
			n = n ^ 16'hB400; // taps 16 14 13 11
		return n;
	endfunction

	// one lfsr step per bit taken
	task automatic take_bits(input int n, output logic [15:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[14:0], lfsr_q[0]};
			lfsr_q = lfsr_next(lfsr_q);
		end
	endtask

	function automatic logic [`ADDR_W-1:0] make_addr(input logic [`TAG_W-1:0] tag,
			input logic [`SET_W-1:0] set, input logic [2:0] word);
		return {tag, set, word, 1'b0}; // word aligned byte address
	endfunction

	task automatic model_reset();
		for (int i = 0; i < 2**`MEM_AW; i++)
			ref_mem[i] = 16'(i) ^ 16'hA5C3; // memory image, index xor a5c3
		for (int s = 0; s < `NUM_SETS; s++) begin
			for (int w = 0; w < 2; w++) begin
				ref_valid[s][w] = 1'b0;
				ref_tag[s][w]   = '0;
				ref_lru_n[s][w] = 1'b0; // cold
			end
		end
	endtask

	// way holding the address tag, -1 when absent
	function automatic int ref_way(input logic [`ADDR_W-1:0] a);
		logic [`SET_W-1:0] st;
		int                found;
		st = a[`OFS_W +: `SET_W];
		found = -1;
		for (int w = 0; w < 2; w++) begin
			if (ref_valid[st][w] && ref_tag[st][w] == a[`ADDR_W-1 -: `TAG_W])
				found = w;
		end
		return found;
	endfunction

	// expected response, computed before the model is updated
	function automatic cpu_rsp_t predict_rsp(input cpu_req_t r);
		cpu_rsp_t p;
		p.hit   = (ref_way(r.addr) >= 0);
		p.rdata = r.write ? '0 : ref_mem[r.addr[`ADDR_W-1:1]]; // cache always mirrors memory
		return p;
	endfunction

	task automatic model_apply(input cpu_req_t r);
		logic [`SET_W-1:0] st;
		int                w;
		st = r.addr[`OFS_W +: `SET_W];
		w  = ref_way(r.addr);
		if (r.write) begin
			ref_mem[r.addr[`ADDR_W-1:1]] = r.wdata; // no allocate, lru untouched
		end else begin
			if (w < 0) begin
				if (!ref_lru_n[st][0] && !ref_lru_n[st][1])
					w = 0; // cold set
				else if (!ref_lru_n[st][0])
					w = 0;
				else
					w = 1;
				ref_valid[st][w] = 1'b1;
				ref_tag[st][w]   = r.addr[`ADDR_W-1 -: `TAG_W];
			end
			ref_lru_n[st][w]     = 1'b1; // most recently used
			ref_lru_n[st][1 - w] = 1'b0;
		end
	endtask

	task automatic check_eq(input logic [31:0] got, input logic [31:0] want, input string what);
		if (got !== want) begin
			mismatch_cnt++;
			$display("MISMATCH at %0t ns: %s, got %0h expected %0h", $time, what, got, want);
		end
	endtask

	// want_hit -1 leaves the hit to the model alone
	task automatic do_req(input logic write, input logic [`ADDR_W-1:0] a,
			input logic [`WORD_W-1:0] d, input int want_hit);
		cpu_req_t r;
		exp_t     e;
		r.write = write;
		r.addr  = a;
		r.wdata = d;
		e.rsp   = predict_rsp(r);
		if (want_hit >= 0)
			check_eq(32'(e.rsp.hit), want_hit, $sformatf("expected hit for %h", a));
		model_apply(r);
		while (busy)
			@(negedge clk);
		e.fast   = write | e.rsp.hit;
		e.write  = write;
		e.addr   = a;
		e.issued = cycle;
		exp_q.push_back(e);
		req_valid = 1'b1;
		req       = r;
		req_cnt++;
		@(negedge clk);
		req_valid = 1'b0;
		req       = '0;
		check_eq(32'(busy), 1, "busy after request");
		while (busy)
			@(negedge clk);
	endtask

	task automatic random_mix(input int n);
		logic [15:0]       op, ti, si, wi, wd;
		logic [`TAG_W-1:0] tg;
		logic [`SET_W-1:0] st;
		for (int i = 0; i < n; i++) begin
			take_bits(2, op);
			take_bits(2, ti);
			take_bits(2, si);
			take_bits(3, wi);
			take_bits(16, wd);
			case (ti[1:0]) // small pools, so sets see conflicts
				2'd0:    tg = 6'h00;
				2'd1:    tg = 6'h15;
				2'd2:    tg = 6'h2A;
				default: tg = 6'h3F;
			endcase
			case (si[1:0])
				2'd0:    st = 6'd0;
				2'd1:    st = 6'd5;
				2'd2:    st = 6'd33;
				default: st = 6'd63;
			endcase
			do_req(op[1:0] == 2'b00, make_addr(tg, st, wi[2:0]), wd, -1); // one store in four
		end
	endtask

	always @(negedge clk) begin : compare_rsp
		exp_t  e;
		int    lat;
		string tag_s;
		if (!rst && rsp_valid) begin
			rsp_cnt++;
			if (exp_q.size() == 0) begin
				other_cnt++;
				$display("ERROR at %0t ns: response without an outstanding request", $time);
			end else begin
				e     = exp_q.pop_front();
				lat   = int'(cycle - e.issued);
				tag_s = $sformatf("%s %h", e.write ? "store" : "load", e.addr);
				check_eq(32'(rsp.rdata), 32'(e.rsp.rdata), {tag_s, " rdata"});
				check_eq(32'(rsp.hit), 32'(e.rsp.hit), {tag_s, " hit"});
				if (e.fast)
					check_eq(32'(lat), 2, {tag_s, " latency"});
				else
					check_eq(32'(lat > 2 && lat <= MISS_BOUND), 1, {tag_s, " miss latency in range"});
			end
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog: run did not finish, %0d of %0d requests answered", rsp_cnt, req_cnt);
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		rst       = 1'b1;
		req_valid = 1'b0;
		req       = '0;
		lfsr_q    = 16'd11111;
		model_reset();
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		repeat (4) begin // idle after reset
			@(negedge clk);
			check_eq(32'(busy), 0, "busy before first request");
			check_eq(32'(rsp_valid), 0, "rsp_valid before first request");
		end
		// cold loads miss and return the memory image
		do_req(1'b0, make_addr(6'h05, 6'd10, 3'd3), '0, 0);
		do_req(1'b0, make_addr(6'h3A, 6'd20, 3'd0), '0, 0);
		do_req(1'b0, make_addr(6'h00, 6'd0, 3'd7), '0, 0);
		do_req(1'b0, make_addr(6'h05, 6'd10, 3'd3), '0, 1); // same block hits
		do_req(1'b0, make_addr(6'h05, 6'd10, 3'd6), '0, 1);
		do_req(1'b0, make_addr(6'h05, 6'd10, 3'd3), '0, 1);
		// three tags in set 40
		do_req(1'b0, make_addr(6'h11, 6'd40, 3'd0), '0, 0);
		do_req(1'b0, make_addr(6'h22, 6'd40, 3'd1), '0, 0);
		do_req(1'b0, make_addr(6'h11, 6'd40, 3'd2), '0, 1);
		do_req(1'b0, make_addr(6'h33, 6'd40, 3'd3), '0, 0); // evicts 22
		do_req(1'b0, make_addr(6'h11, 6'd40, 3'd4), '0, 1);
		do_req(1'b0, make_addr(6'h22, 6'd40, 3'd5), '0, 0); // evicts 33
		do_req(1'b0, make_addr(6'h11, 6'd40, 3'd7), '0, 1);
		do_req(1'b0, make_addr(6'h22, 6'd40, 3'd0), '0, 1);
		// store hit updates the block, store miss only memory
		do_req(1'b0, make_addr(6'h0C, 6'd50, 3'd2), '0, 0);
		do_req(1'b1, make_addr(6'h0C, 6'd50, 3'd2), 16'hBEEF, 1);
		do_req(1'b0, make_addr(6'h0C, 6'd50, 3'd2), '0, 1);
		do_req(1'b1, make_addr(6'h2D, 6'd50, 3'd4), 16'h1234, 0);
		do_req(1'b0, make_addr(6'h2D, 6'd50, 3'd4), '0, 0);
		do_req(1'b0, make_addr(6'h0C, 6'd50, 3'd2), '0, 1);
		random_mix(N_RAND);
		repeat (4) @(negedge clk);
		check_eq(32'(rsp_cnt), 32'(req_cnt), "responses against requests");
		check_eq(32'(exp_q.size()), 0, "responses still outstanding");
		$display("errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
		if (mismatch_cnt + other_cnt == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule
